//--- barrier_pkg.sv
package barrier_pkg;

    typedef logic [3:0] conn_id_t;
    typedef logic [3:0] context_id_t;
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_BROADCAST = 4'd5;
    localparam opcode_t OP_ANSWER    = 4'd6;

    localparam int NUM_CONNS = 4;
    localparam int NUM_SLOTS = 2;

    typedef struct packed {
        logic     enable;
        conn_id_t conn_id;
    } conn_entry_t;

    // also used as a slot context table, slot bit then means armed
    typedef struct packed {
        logic                        slot;
        context_id_t                 context_id;
        conn_entry_t [NUM_CONNS-1:0] conns;       // entry 0 in low bits
    } barrier_req_t;

    typedef struct packed {
        conn_id_t    conn_id;
        context_id_t context_id;
        logic        is_broadcast;   // low for an answer
    } rx_msg_t;

    typedef struct packed {
        conn_id_t    dest;
        context_id_t context_id;
        opcode_t     opcode;
    } chan_msg_t;

    // state names the next connection entry to examine
    typedef enum logic [1:0] {
        IDLE,
        SEND_CONN1,
        SEND_CONN2,
        SEND_CONN3
    } seq_state_t;

endpackage

//--- barrier_request_queue.sv
`timescale 1ns/100ps

module barrier_request_queue
(
    input  logic                      clk,
    input  logic                      reset,
    input  barrier_pkg::barrier_req_t req,
    input  logic                      req_valid,
    input  logic                      head_pop,
    output logic                      req_ready,
    output barrier_pkg::barrier_req_t head,
    output logic                      head_valid
);
    barrier_pkg::barrier_req_t back;
    logic                      back_valid;
    logic                      take;
    logic                      advance;

    assign req_ready = ~back_valid;
    assign take      = req_valid & req_ready;
    assign advance   = ~head_valid | head_pop;   // front is free this cycle

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            head_valid <= 1'b0;
            back_valid <= 1'b0;
        end
        else if (advance)
        begin
            head_valid <= back_valid | take;
            back_valid <= 1'b0;
        end
        else if (take)
            back_valid <= 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (advance)
            head <= back_valid ? back : req;   // refill from back first
        if (take && !advance)
            back <= req;
    end

endmodule

//--- barrier_sequencer.sv
`timescale 1ns/100ps

module barrier_sequencer
(
    input  logic                      clk,
    input  logic                      reset,
    input  barrier_pkg::barrier_req_t head,
    input  logic                      head_valid,
    input  barrier_pkg::rx_msg_t      rx,
    input  logic                      rx_valid,
    input  logic                      space,
    output logic                      head_pop,
    output logic                      rx_ready,
    output logic                      push,
    output barrier_pkg::chan_msg_t    push_msg,
    output logic                      req_done,
    output logic                      req_done_slot,
    output logic                      rx_accepted
);
    localparam int IDX_W = $clog2(barrier_pkg::NUM_CONNS);

    barrier_pkg::seq_state_t           state;
    barrier_pkg::seq_state_t           next_state;
    logic [barrier_pkg::NUM_CONNS-1:0] pending;
    logic [IDX_W-1:0]                  first_idx;
    logic                              more;

    always_comb
    begin
        pending   = '0;
        first_idx = '0;
        more      = 1'b0;
        for (int i = 0; i < barrier_pkg::NUM_CONNS; i++)
            pending[i] = head.conns[i].enable && (i >= int'(state));
        for (int i = barrier_pkg::NUM_CONNS - 1; i >= 0; i--)
        begin
            if (pending[i])
                first_idx = IDX_W'(i);
        end
        for (int i = 0; i < barrier_pkg::NUM_CONNS; i++)
        begin
            if (pending[i] && i > int'(first_idx))
                more = 1'b1;
        end
    end

    always_comb
    begin
        next_state          = state;
        head_pop            = 1'b0;
        rx_ready            = 1'b0;
        push                = 1'b0;
        push_msg.dest       = rx.conn_id;
        push_msg.context_id = rx.context_id;
        push_msg.opcode     = barrier_pkg::OP_ANSWER;
        if (space)
        begin
            if (head_valid)                                  // local request first
            begin
                push_msg.dest       = head.conns[first_idx].conn_id;
                push_msg.context_id = head.context_id;
                push_msg.opcode     = barrier_pkg::OP_BROADCAST;
                push                = |pending;                 // empty request pops silently
                if (more)
                    next_state = barrier_pkg::seq_state_t'(first_idx + 1);
                else
                begin
                    head_pop   = 1'b1;
                    next_state = barrier_pkg::IDLE;
                end
            end
            else if (rx_valid && state == barrier_pkg::IDLE)
            begin
                rx_ready = 1'b1;
                push     = rx.is_broadcast;   // remote answer is absorbed
            end
        end
    end

    assign req_done      = head_pop;
    assign req_done_slot = head.slot;
    assign rx_accepted   = rx_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
            state <= barrier_pkg::IDLE;
        else
            state <= next_state;
    end

    rx_vs_pop: assert property (@(posedge clk) disable iff (reset) !(rx_ready && head_pop));

endmodule

//--- message_fifo.sv
`timescale 1ns/100ps

module message_fifo #(
    parameter int DEPTH = 4
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   push,
    input  barrier_pkg::chan_msg_t push_msg,
    input  logic                   pop,
    output logic                   space,
    output barrier_pkg::chan_msg_t out_msg,
    output logic                   not_empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    barrier_pkg::chan_msg_t mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;

    assign space     = count != CNT_W'(DEPTH);
    assign not_empty = count != '0;
    assign out_msg   = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= push_msg;
    end

    no_overflow:  assert property (@(posedge clk) disable iff (reset) push |-> space);
    no_underflow: assert property (@(posedge clk) disable iff (reset) pop |-> not_empty);

endmodule

//--- channel_sender.sv
`timescale 1ns/100ps

module channel_sender #(
    parameter int CHANNEL_CREDITS = 2
)
(
    input  logic                   clk,
    input  logic                   reset,
    input  barrier_pkg::chan_msg_t out_msg,
    input  logic                   not_empty,
    input  logic                   credit_return,
    output logic                   pop,
    output barrier_pkg::chan_msg_t channel,
    output logic                   channel_valid
);
    localparam int CNT_W = $clog2(CHANNEL_CREDITS + 1);

    logic [CNT_W-1:0] credits;

    assign pop = not_empty && (credits != '0);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            credits       <= CNT_W'(CHANNEL_CREDITS);
            channel_valid <= 1'b0;
        end
        else
        begin
            credits       <= credits - CNT_W'(pop) + CNT_W'(credit_return);   // spend and return together
            channel_valid <= pop;
        end
    end

    always_ff @(posedge clk)
    begin
        if (pop)
            channel <= out_msg;
    end

    // the far side never hands back more than it was given
    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= CNT_W'(CHANNEL_CREDITS));

endmodule

//--- barrier_tracker.sv
`timescale 1ns/100ps

module barrier_tracker
(
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  barrier_pkg::barrier_req_t [barrier_pkg::NUM_SLOTS-1:0] context_table,
    input  logic [barrier_pkg::NUM_SLOTS-1:0]                    clean,
    input  barrier_pkg::rx_msg_t                                 rx,
    input  logic                                                 rx_accepted,
    input  logic                                                 req_done,
    input  logic                                                 req_done_slot,
    output logic [barrier_pkg::NUM_SLOTS-1:0]                    done
);
    localparam int NS = barrier_pkg::NUM_SLOTS;
    localparam int NC = barrier_pkg::NUM_CONNS;

    logic [NS-1:0]         sent;
    logic [NS-1:0][NC-1:0] bcast_seen;
    logic [NS-1:0][NC-1:0] answer_seen;
    logic [NS-1:0][NC-1:0] bcast_set;
    logic [NS-1:0][NC-1:0] answer_set;
    logic [NS-1:0][NC-1:0] enables;

    always_comb
    begin
        logic          hit;
        logic [NC-1:0] sel;
        for (int s = 0; s < NS; s++)
        begin
            hit = rx_accepted && context_table[s].slot
                  && context_table[s].context_id == rx.context_id;
            sel = '0;
            for (int i = 0; i < NC; i++)
            begin
                enables[s][i] = context_table[s].conns[i].enable;
                // later hits override, so the highest connection wins
                if (hit && enables[s][i] && context_table[s].conns[i].conn_id == rx.conn_id
                    && !(rx.is_broadcast ? bcast_seen[s][i] : answer_seen[s][i]))
                begin
                    sel    = '0;
                    sel[i] = 1'b1;
                end
            end
            bcast_set[s]  = rx.is_broadcast ? sel : '0;
            answer_set[s] = rx.is_broadcast ? '0 : sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            sent        <= '0;
            bcast_seen  <= '0;
            answer_seen <= '0;
            done        <= '0;
        end
        else
        begin
            for (int s = 0; s < NS; s++)
            begin
                if (clean[s])
                begin
                    sent[s]        <= 1'b0;
                    bcast_seen[s]  <= '0;
                    answer_seen[s] <= '0;
                    done[s]        <= 1'b0;
                end
                else
                begin
                    if (req_done && int'(req_done_slot) == s)
                        sent[s] <= 1'b1;
                    bcast_seen[s]  <= bcast_seen[s] | bcast_set[s];
                    answer_seen[s] <= answer_seen[s] | answer_set[s];
                    done[s]        <= sent[s] && ((bcast_seen[s] & enables[s]) == enables[s])
                                      && ((answer_seen[s] & enables[s]) == enables[s]);
                end
            end
        end
    end

endmodule

//--- barrier_tx.sv
`timescale 1ns/100ps

module barrier_tx #(
    parameter int FIFO_DEPTH      = 4,
    parameter int CHANNEL_CREDITS = 2
)
(
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  barrier_pkg::barrier_req_t                            req,
    input  logic                                                 req_valid,
    output logic                                                 req_ready,
    input  barrier_pkg::rx_msg_t                                 rx,
    input  logic                                                 rx_valid,
    output logic                                                 rx_ready,
    output barrier_pkg::chan_msg_t                               channel,
    output logic                                                 channel_valid,
    input  logic                                                 credit_return,
    input  barrier_pkg::barrier_req_t [barrier_pkg::NUM_SLOTS-1:0] context_table,
    input  logic [barrier_pkg::NUM_SLOTS-1:0]                    clean,
    output logic [barrier_pkg::NUM_SLOTS-1:0]                    done
);
    barrier_pkg::barrier_req_t head;
    logic                      head_valid;
    logic                      head_pop;
    logic                      push;
    barrier_pkg::chan_msg_t    push_msg;
    logic                      space;
    barrier_pkg::chan_msg_t    out_msg;
    logic                      not_empty;
    logic                      pop;
    logic                      req_done;
    logic                      req_done_slot;
    logic                      rx_accepted;

    barrier_request_queue queue_i (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .head_pop   (head_pop),
        .req_ready  (req_ready),
        .head       (head),
        .head_valid (head_valid)
    );

    barrier_sequencer sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .head          (head),
        .head_valid    (head_valid),
        .rx            (rx),
        .rx_valid      (rx_valid),
        .space         (space),
        .head_pop      (head_pop),
        .rx_ready      (rx_ready),
        .push          (push),
        .push_msg      (push_msg),
        .req_done      (req_done),
        .req_done_slot (req_done_slot),
        .rx_accepted   (rx_accepted)
    );

    message_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) fifo_i (
        .clk       (clk),
        .reset     (reset),
        .push      (push),
        .push_msg  (push_msg),
        .pop       (pop),
        .space     (space),
        .out_msg   (out_msg),
        .not_empty (not_empty)
    );

    channel_sender #(
        .CHANNEL_CREDITS (CHANNEL_CREDITS)
    ) sender_i (
        .clk           (clk),
        .reset         (reset),
        .out_msg       (out_msg),
        .not_empty     (not_empty),
        .credit_return (credit_return),
        .pop           (pop),
        .channel       (channel),
        .channel_valid (channel_valid)
    );

    barrier_tracker tracker_i (
        .clk           (clk),
        .reset         (reset),
        .context_table (context_table),
        .clean         (clean),
        .rx            (rx),
        .rx_accepted   (rx_accepted),
        .req_done      (req_done),
        .req_done_slot (req_done_slot),
        .done          (done)
    );

endmodule

//--- barrier_tx_tb.sv
`timescale 1ns/100ps

module barrier_tx_tb;
    localparam int FIFO_DEPTH  = 4;
    localparam int CREDITS     = 2;
    localparam int NUM_STEPS   = 18;
    localparam int CYCLE_LIMIT = 200 * NUM_STEPS;

    typedef enum logic [1:0] {STEP_REQ, STEP_RX, STEP_CLEAN, STEP_STALL} step_kind_t;

    // sel is the slot for a request, is_broadcast for rx, the slot mask for a clean
    typedef struct packed {
        step_kind_t                 kind;
        logic [1:0]                 sel;
        barrier_pkg::context_id_t   ctx;
        logic [3:0]                 mask;
        barrier_pkg::conn_id_t      conn;
        logic [1:0]                 armed;
    } step_t;

    logic                                                  clk;
    logic                                                  reset;
    barrier_pkg::barrier_req_t                             req;
    logic                                                  req_valid;
    logic                                                  req_ready;
    barrier_pkg::rx_msg_t                                  rx;
    logic                                                  rx_valid;
    logic                                                  rx_ready;
    barrier_pkg::chan_msg_t                                channel;
    logic                                                  channel_valid;
    logic                                                  credit_return;
    barrier_pkg::barrier_req_t [barrier_pkg::NUM_SLOTS-1:0] context_table;
    logic [barrier_pkg::NUM_SLOTS-1:0]                     clean;
    logic [barrier_pkg::NUM_SLOTS-1:0]                     done;

    step_t                  steps [NUM_STEPS];
    barrier_pkg::chan_msg_t exp_q [$];
    logic [1:0]             m_sent;
    logic [1:0][3:0]        m_bcast;
    logic [1:0][3:0]        m_answer;
    logic                   stall;
    int                     stall_seen;
    int                     outstanding;
    int                     cycles;

    barrier_tx #(
        .FIFO_DEPTH      (FIFO_DEPTH),
        .CHANNEL_CREDITS (CREDITS)
    ) dut_i (
        .clk           (clk),
        .reset         (reset),
        .req           (req),
        .req_valid     (req_valid),
        .req_ready     (req_ready),
        .rx            (rx),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .channel       (channel),
        .channel_valid (channel_valid),
        .credit_return (credit_return),
        .context_table (context_table),
        .clean         (clean),
        .done          (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_msg(input barrier_pkg::chan_msg_t got, input barrier_pkg::chan_msg_t exp);
        if (got !== exp)
            fail_run($sformatf("FAIL %0t channel got 0x%h expected 0x%h", $time, got, exp));
    endtask

    task automatic check_done(input logic [barrier_pkg::NUM_SLOTS-1:0] got,
                              input logic [barrier_pkg::NUM_SLOTS-1:0] exp);
        if (got !== exp)
            fail_run($sformatf("FAIL %0t done got %b expected %b", $time, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("FAIL %0t %s got %b expected %b", $time, name, got, exp));
    endtask

    function automatic barrier_pkg::barrier_req_t req_of(input logic slot,
            input barrier_pkg::context_id_t ctx, input logic [3:0] mask,
            input barrier_pkg::conn_id_t base);
        barrier_pkg::barrier_req_t r;
        r.slot       = slot;
        r.context_id = ctx;
        for (int i = 0; i < barrier_pkg::NUM_CONNS; i++)
        begin
            r.conns[i].enable  = mask[i];
            r.conns[i].conn_id = base + barrier_pkg::conn_id_t'(i);
        end
        return r;
    endfunction

    function automatic step_t step_of(input step_kind_t kind, input logic [1:0] sel,
            input barrier_pkg::context_id_t ctx, input logic [3:0] mask,
            input barrier_pkg::conn_id_t conn, input logic [1:0] armed);
        step_t st;
        st.kind  = kind;
        st.sel   = sel;
        st.ctx   = ctx;
        st.mask  = mask;
        st.conn  = conn;
        st.armed = armed;
        return st;
    endfunction

    // highest enabled matching connection without the bit gets it
    task automatic track_rx(input barrier_pkg::rx_msg_t m);
        logic found;
        for (int s = 0; s < barrier_pkg::NUM_SLOTS; s++)
        begin
            found = 1'b0;
            if (context_table[s].slot && context_table[s].context_id == m.context_id)
            begin
                for (int i = barrier_pkg::NUM_CONNS - 1; i >= 0; i--)
                begin
                    if (!found && context_table[s].conns[i].enable
                        && context_table[s].conns[i].conn_id == m.conn_id
                        && !(m.is_broadcast ? m_bcast[s][i] : m_answer[s][i]))
                    begin
                        found = 1'b1;
                        if (m.is_broadcast)
                            m_bcast[s][i] = 1'b1;
                        else
                            m_answer[s][i] = 1'b1;
                    end
                end
            end
        end
    endtask

    function automatic logic [1:0] model_done();
        logic [1:0] d;
        for (int s = 0; s < barrier_pkg::NUM_SLOTS; s++)
        begin
            d[s] = m_sent[s];
            for (int i = 0; i < barrier_pkg::NUM_CONNS; i++)
            begin
                if (context_table[s].conns[i].enable && !(m_bcast[s][i] && m_answer[s][i]))
                    d[s] = 1'b0;
            end
        end
        return d;
    endfunction

    task automatic send_req(input barrier_pkg::barrier_req_t r);
        req       = r;
        req_valid = 1'b1;
        @(negedge clk);
        while (!req_ready)
        begin
            @(posedge clk);
            @(negedge clk);
        end
        @(posedge clk);   // taken here
        #1 req_valid = 1'b0;
    endtask

    task automatic send_rx(input barrier_pkg::rx_msg_t m);
        rx       = m;
        rx_valid = 1'b1;
        @(negedge clk);
        while (!rx_ready)
        begin
            @(posedge clk);
            @(negedge clk);
        end
        @(posedge clk);
        #1 rx_valid = 1'b0;
    endtask

    task automatic apply_step(input step_t st);
        barrier_pkg::barrier_req_t r;
        barrier_pkg::rx_msg_t      m;
        barrier_pkg::chan_msg_t    e;
        context_table[0] = req_of(st.armed[0], 4'd3, 4'b1111, 4'd8);
        context_table[1] = req_of(st.armed[1], 4'd9, 4'b0001, 4'd0);
        case (st.kind)
            STEP_REQ, STEP_STALL:
            begin
                r = req_of(st.sel[0], st.ctx, st.mask, st.conn);
                for (int i = 0; i < barrier_pkg::NUM_CONNS; i++)
                begin
                    if (st.mask[i])
                    begin
                        e.dest       = r.conns[i].conn_id;
                        e.context_id = st.ctx;
                        e.opcode     = barrier_pkg::OP_BROADCAST;
                        exp_q.push_back(e);
                    end
                end
                m_sent[st.sel[0]] = 1'b1;
                stall = (st.kind == STEP_STALL);
                send_req(r);
                if (stall)
                begin
                    repeat (30) @(posedge clk);
                    #1;
                    if (stall_seen > CREDITS)
                        fail_run("more messages left than the channel had credits for");
                    stall = 1'b0;
                end
            end
            STEP_RX:
            begin
                m.conn_id      = st.conn;
                m.context_id   = st.ctx;
                m.is_broadcast = st.sel[0];
                if (m.is_broadcast)
                begin
                    e.dest       = st.conn;
                    e.context_id = st.ctx;
                    e.opcode     = barrier_pkg::OP_ANSWER;
                    exp_q.push_back(e);
                end
                track_rx(m);
                send_rx(m);
            end
            default:
            begin
                clean = st.sel;
                @(posedge clk);
                #1 clean = '0;
                for (int s = 0; s < barrier_pkg::NUM_SLOTS; s++)
                begin
                    if (st.sel[s])
                    begin
                        m_sent[s]   = 1'b0;
                        m_bcast[s]  = '0;
                        m_answer[s] = '0;
                    end
                end
            end
        endcase
    endtask

    task automatic wait_settle();
        while (exp_q.size() != 0)
            @(posedge clk);
        repeat (10) @(posedge clk);
        #1;
    endtask

    // channel monitor, credit returns and run limit
    initial
    begin
        credit_return = 1'b0;
        outstanding   = 0;
        stall_seen    = 0;
        cycles        = 0;
        forever
        begin
            @(posedge clk);
            #2;
            cycles++;
            if (cycles >= CYCLE_LIMIT)
                fail_run("timeout, the run did not finish within the cycle limit");
            if (channel_valid)
            begin
                if (exp_q.size() == 0)
                    fail_run("channel sent a message that was not expected");
                else
                    check_msg(channel, exp_q.pop_front());
                outstanding++;
            end
            if (!stall)
                stall_seen = 0;
            else if (channel_valid)
                stall_seen++;
            credit_return = 1'b0;
            if (!stall && outstanding != 0 && ($urandom & 32'd1) == 32'd1)
            begin
                credit_return = 1'b1;   // random gaps between returns
                outstanding--;
            end
        end
    end

    initial
    begin
        void'($urandom(32'h4f7e));
        reset         = 1'b1;
        req           = '0;
        req_valid     = 1'b0;
        rx            = '0;
        rx_valid      = 1'b0;
        context_table = '0;
        clean         = '0;
        stall         = 1'b0;
        m_sent        = '0;
        m_bcast       = '0;
        m_answer      = '0;
        steps[0]  = step_of(STEP_REQ,   2'd0, 4'd3, 4'b1111, 4'd8,  2'b11);
        steps[1]  = step_of(STEP_RX,    2'd1, 4'd3, 4'b0000, 4'd8,  2'b11);
        steps[2]  = step_of(STEP_RX,    2'd1, 4'd3, 4'b0000, 4'd9,  2'b11);
        steps[3]  = step_of(STEP_RX,    2'd1, 4'd3, 4'b0000, 4'd10, 2'b11);
        steps[4]  = step_of(STEP_RX,    2'd1, 4'd3, 4'b0000, 4'd11, 2'b11);
        steps[5]  = step_of(STEP_RX,    2'd0, 4'd3, 4'b0000, 4'd8,  2'b11);
        steps[6]  = step_of(STEP_RX,    2'd0, 4'd3, 4'b0000, 4'd9,  2'b11);
        steps[7]  = step_of(STEP_RX,    2'd0, 4'd3, 4'b0000, 4'd10, 2'b11);
        steps[8]  = step_of(STEP_RX,    2'd0, 4'd7, 4'b0000, 4'd11, 2'b11);   // other context
        steps[9]  = step_of(STEP_RX,    2'd0, 4'd3, 4'b0000, 4'd11, 2'b11);
        steps[10] = step_of(STEP_CLEAN, 2'b01, 4'd0, 4'b0000, 4'd0, 2'b11);
        steps[11] = step_of(STEP_REQ,   2'd0, 4'd9, 4'b1010, 4'd4,  2'b11);
        steps[12] = step_of(STEP_REQ,   2'd1, 4'd9, 4'b0000, 4'd0,  2'b11);
        steps[13] = step_of(STEP_RX,    2'd0, 4'd9, 4'b0000, 4'd0,  2'b01);   // slot 1 unarmed
        steps[14] = step_of(STEP_RX,    2'd1, 4'd9, 4'b0000, 4'd0,  2'b11);
        steps[15] = step_of(STEP_RX,    2'd0, 4'd9, 4'b0000, 4'd0,  2'b11);
        steps[16] = step_of(STEP_STALL, 2'd0, 4'd3, 4'b1111, 4'd12, 2'b11);
        steps[17] = step_of(STEP_CLEAN, 2'b10, 4'd0, 4'b0000, 4'd0, 2'b11);
        repeat (16) @(posedge clk);
        #1 reset = 1'b0;
        check_flag("req_ready", req_ready, 1'b1);
        check_flag("rx_ready", rx_ready, 1'b0);
        check_flag("channel_valid", channel_valid, 1'b0);
        check_done(done, '0);
        for (int n = 0; n < NUM_STEPS; n++)
        begin
            apply_step(steps[n]);
            wait_settle();
            check_done(done, model_done());
        end
        $display("all tests passed");
        $finish;
    end

endmodule

//--- barrier_tx.f
barrier_pkg.sv
barrier_request_queue.sv
barrier_sequencer.sv
message_fifo.sv
channel_sender.sv
barrier_tracker.sv
barrier_tx.sv
barrier_tx_tb.sv

//--- run.sh
#!/bin/sh
# build with Verilator and run, the exit status carries the result
verilator --binary --timing --assert --top-module barrier_tx_tb -f barrier_tx.f -o barrier_tx_sim \
    && ./obj_dir/barrier_tx_sim \
    || exit 1
